/* Makefile */
# rom loader simulation with verilator
all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -f sources.f --top-module tb_rom_loader

run: build
	out=$$(./obj_dir/Vtb_rom_loader); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f sources.f --top-module tb_rom_loader
	verilator --lint-only --timing --timescale 1ns/100ps -f sources.f --top-module rom_loader_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* hw/dl_word_assembler.sv */
`timescale 1ns/100ps
`include "loader_cfg.svh"

module dl_word_assembler import loader_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic [7:0] ioctl_index,
	input logic [26:0] ioctl_addr,
	input logic [15:0] ioctl_dout,
	output logic ioctl_wait,
	output logic [`PIF_ADDR_BITS-1:0] pifrom_wraddress,
	output mem_word_t pifrom_wrdata,
	output logic pifrom_wren,
	output logic cart_loaded,
	mem_port_if.client mem
);

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_PIF,
		TGT_N64,
		TGT_GB
	} target_t;

	localparam mem_addr_t N64_BASE = mem_addr_t'(`CART_N64_BASE);
	localparam mem_addr_t GB_BASE = mem_addr_t'(`CART_GB_BASE);

	target_t target;
	target_t next_target;
	logic wr_lo;
	logic wr_hi;
	logic is_cart;
	logic req_q;
	mem_addr_t cart_base;
	mem_addr_t cart_addr;
	mem_word_t cart_wdata;

	// ========================================
	// target decode and half strobes
	// ========================================

	always_comb begin
		next_target = TGT_NONE;
		if (ioctl_download) begin
			case (ioctl_index[5:0])
				`DL_IDX_PIF: next_target = TGT_PIF;
				`DL_IDX_N64: next_target = TGT_N64;
				`DL_IDX_GB: next_target = TGT_GB;
				default: next_target = TGT_NONE;
			endcase
		end
	end

	// bit 1 picks the half within a word
	assign wr_lo = ioctl_wr && !ioctl_addr[1];
	assign wr_hi = ioctl_wr && ioctl_addr[1];
	assign is_cart = (target == TGT_N64) || (target == TGT_GB);
	assign cart_base = (target == TGT_N64) ? N64_BASE : GB_BASE;

	// ========================================
	// control state
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			target <= TGT_NONE;
			pifrom_wren <= 1'b0;
			req_q <= 1'b0;
			ioctl_wait <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			// decode lags the host by one cycle
			target <= next_target;
			// one-cycle strobe per completed boot rom word
			pifrom_wren <= (target == TGT_PIF) && wr_hi;
			// req up on the high half, down once ack seen
			if (is_cart && wr_hi) begin
				req_q <= 1'b1;
			end else if (mem.ack) begin
				req_q <= 1'b0;
			end
			// hold the host until the handshake has fully closed
			if (is_cart && wr_hi) begin
				ioctl_wait <= 1'b1;
			end else if (!is_cart) begin
				ioctl_wait <= 1'b0;
			end else if (!req_q && !mem.ack) begin
				ioctl_wait <= 1'b0;
			end
			// sticky until reset
			if (target == TGT_N64) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// ========================================
	// word assembly
	// ========================================

	always_ff @(posedge clk_1x) begin
		if ((target == TGT_PIF) && wr_lo) begin
			// byte swapped, low half lands on top
			pifrom_wrdata[31:16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
			pifrom_wraddress <= {ioctl_index[6], ioctl_addr[`PIF_ADDR_BITS:2]};
		end
		if ((target == TGT_PIF) && wr_hi) begin
			pifrom_wrdata[15:0] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
		end
		if (is_cart && wr_lo) begin
			cart_wdata[15:0] <= ioctl_dout;
			// wraps inside the scaled memory space
			cart_addr <= mem_addr_t'(ioctl_addr + 27'(cart_base));
		end
		if (is_cart && wr_hi) begin
			cart_wdata[31:16] <= ioctl_dout;
		end
	end

	// write-only client, full words
	assign mem.req = req_q;
	assign mem.rnw = 1'b0;
	assign mem.addr = cart_addr;
	assign mem.be = MEM_BE_ALL;
	assign mem.wdata = cart_wdata;

	// req holds until the arbiter has acked
	assert property (@(posedge clk_1x) disable iff (reset)
		$fell(mem.req) |-> mem.ack)
		else $error("cartridge req dropped before ack");

endmodule

/* hw/loader_pkg.sv */
`include "loader_cfg.svh"

package loader_pkg;

	// ========================================
	// memory bus types
	// ========================================

	// byte address into the shared word array
	typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

	// one 32-bit memory word
	typedef logic [31:0] mem_word_t;

	// byte enables
	// bit n covers word bits 8n+7 down to 8n
	typedef logic [3:0] mem_be_t;

	// all four lanes, used by the cartridge loader
	localparam mem_be_t MEM_BE_ALL = 4'hf;

endpackage

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import loader_pkg::*; (
	input logic clk_1x,
	input logic reset,
	mem_port_if.arbiter dl,
	mem_port_if.arbiter sys,
	output logic mem_en,
	output logic mem_we,
	output mem_addr_t mem_addr,
	output mem_be_t mem_be,
	output mem_word_t mem_wdata,
	input mem_word_t mem_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_ACK,
		ST_RELEASE
	} arb_state_t;

	arb_state_t state;
	// 0 = download port, 1 = system port
	logic grant_sys;
	logic dl_ack_q;
	logic sys_ack_q;
	logic sel_req;
	logic sel_rnw;
	mem_word_t rdata_q;

	// ========================================
	// granted client mux
	// ========================================

	assign sel_req = grant_sys ? sys.req : dl.req;
	assign sel_rnw = grant_sys ? sys.rnw : dl.rnw;

	// single access cycle right after the grant
	assign mem_en = (state == ST_ACCESS);
	assign mem_we = mem_en && !sel_rnw;
	assign mem_addr = grant_sys ? sys.addr : dl.addr;
	assign mem_be = grant_sys ? sys.be : dl.be;
	assign mem_wdata = grant_sys ? sys.wdata : dl.wdata;

	// ========================================
	// handshake fsm
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			state <= ST_IDLE;
			grant_sys <= 1'b0;
			dl_ack_q <= 1'b0;
			sys_ack_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// download port first
					if (dl.req) begin
						grant_sys <= 1'b0;
						state <= ST_ACCESS;
					end else if (sys.req) begin
						grant_sys <= 1'b1;
						state <= ST_ACCESS;
					end
				end
				// memory latches the access here
				ST_ACCESS: state <= ST_ACK;
				ST_ACK: begin
					// read data valid now, ack the winner
					if (grant_sys) begin
						sys_ack_q <= 1'b1;
					end else begin
						dl_ack_q <= 1'b1;
					end
					state <= ST_RELEASE;
				end
				ST_RELEASE: begin
					// wait for the client to let go
					if (!sel_req) begin
						dl_ack_q <= 1'b0;
						sys_ack_q <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read word captured alongside ack
	always_ff @(posedge clk_1x) begin
		if (state == ST_ACK) begin
			rdata_q <= mem_rdata;
		end
	end

	assign dl.ack = dl_ack_q;
	assign sys.ack = sys_ack_q;
	// the losing port sees zeros
	assign dl.rdata = grant_sys ? '0 : rdata_q;
	assign sys.rdata = grant_sys ? rdata_q : '0;

	// ack only answers a live request
	// req taken on the edge that raised ack
	assert property (@(posedge clk_1x) disable iff (reset)
		$rose(dl.ack) |-> $past(dl.req))
		else $error("download ack without req");
	assert property (@(posedge clk_1x) disable iff (reset)
		$rose(sys.ack) |-> $past(sys.req))
		else $error("system ack without req");
	// one owner at a time
	assert property (@(posedge clk_1x) disable iff (reset) !(dl.ack && sys.ack))
		else $error("both ports acked together");

endmodule

/* hw/mem_port_if.sv */
`timescale 1ns/100ps

// four-phase req/ack memory port
// client raises req with fields stable, arbiter answers with ack
interface mem_port_if import loader_pkg::*; ();

	// client side
	logic req;
	logic rnw;
	mem_addr_t addr;
	mem_be_t be;
	mem_word_t wdata;

	// arbiter side
	logic ack;
	// valid while ack high, reads only
	mem_word_t rdata;

	modport client (
		output req, rnw, addr, be, wdata,
		input ack, rdata
	);

	modport arbiter (
		input req, rnw, addr, be, wdata,
		output ack, rdata
	);

endinterface

/* hw/rom_loader_top.sv */
`timescale 1ns/100ps
`include "loader_cfg.svh"

module rom_loader_top import loader_pkg::*; (
	input logic clk_1x,
	input logic reset,
	// host download port
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic [7:0] ioctl_index,
	input logic [26:0] ioctl_addr,
	input logic [15:0] ioctl_dout,
	output logic ioctl_wait,
	// boot rom write port
	output logic [`PIF_ADDR_BITS-1:0] pifrom_wraddress,
	output mem_word_t pifrom_wrdata,
	output logic pifrom_wren,
	output logic cart_loaded,
	// system memory port
	input logic sys_req,
	input logic sys_rnw,
	input mem_addr_t sys_addr,
	input mem_be_t sys_be,
	input mem_word_t sys_wdata,
	output logic sys_ack,
	output mem_word_t sys_rdata
);

	mem_port_if dl_port ();
	mem_port_if sys_port ();

	logic mem_en;
	logic mem_we;
	mem_addr_t mem_addr;
	mem_be_t mem_be;
	mem_word_t mem_wdata;
	mem_word_t mem_rdata;

	// ========================================
	// system side onto its port
	// ========================================

	assign sys_port.req = sys_req;
	assign sys_port.rnw = sys_rnw;
	assign sys_port.addr = sys_addr;
	assign sys_port.be = sys_be;
	assign sys_port.wdata = sys_wdata;
	assign sys_ack = sys_port.ack;
	assign sys_rdata = sys_port.rdata;

	dl_word_assembler u_assembler (
		.clk_1x(clk_1x),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_wait(ioctl_wait),
		.pifrom_wraddress(pifrom_wraddress),
		.pifrom_wrdata(pifrom_wrdata),
		.pifrom_wren(pifrom_wren),
		.cart_loaded(cart_loaded),
		.mem(dl_port)
	);

	// download port has priority
	mem_arbiter u_arbiter (
		.clk_1x(clk_1x),
		.reset(reset),
		.dl(dl_port),
		.sys(sys_port),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_be(mem_be),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	word_mem u_mem (
		.clk_1x(clk_1x),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_be(mem_be),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

/* hw/word_mem.sv */
`timescale 1ns/100ps
`include "loader_cfg.svh"

module word_mem import loader_pkg::*; (
	input logic clk_1x,
	input logic mem_en,
	input logic mem_we,
	input mem_addr_t mem_addr,
	input mem_be_t mem_be,
	input mem_word_t mem_wdata,
	output mem_word_t mem_rdata
);

	localparam int WORDS = `MEM_WORDS;

	mem_word_t mem_array [WORDS];
	logic [`MEM_ADDR_BITS-3:0] word_idx;

	// byte address down to word index
	assign word_idx = mem_addr[`MEM_ADDR_BITS-1:2];

	// ========================================
	// single port, write or read per cycle
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (mem_en) begin
			if (mem_we) begin
				// untouched lanes keep their old bytes
				for (int i = 0; i < 4; i++) begin
					if (mem_be[i]) begin
						mem_array[word_idx][8*i +: 8] <= mem_wdata[8*i +: 8];
					end
				end
			end else begin
				// registered read, valid next cycle
				mem_rdata <= mem_array[word_idx];
			end
		end
	end

endmodule

/* include/loader_cfg.svh */
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ========================================
// shared memory geometry
// ========================================

// byte address width, scaled down from the 27-bit sdram space
`define MEM_ADDR_BITS 14
// word count, byte space over four
`define MEM_WORDS (1 << (`MEM_ADDR_BITS - 2))

// cartridge byte bases inside the shared memory
`define CART_N64_BASE 8192
`define CART_GB_BASE 4096

// ========================================
// download targets
// ========================================

// compared against ioctl_index[5:0]
`define DL_IDX_PIF 6'd0
`define DL_IDX_N64 6'd1
`define DL_IDX_GB 6'd2

// boot rom word address width
`define PIF_ADDR_BITS 10

`endif

/* sources.f */
+incdir+include
hw/loader_pkg.sv
hw/mem_port_if.sv
hw/dl_word_assembler.sv
hw/mem_arbiter.sv
hw/word_mem.sv
hw/rom_loader_top.sv
tests/tb_rom_loader.sv

/* tests/tb_rom_loader.sv */
`timescale 1ns/100ps
`include "loader_cfg.svh"

module tb_rom_loader import loader_pkg::*; ();

	typedef enum logic [2:0] {OP_HALF, OP_HALF_SYS, OP_SYS_WR, OP_SYS_RD, OP_FLAG} op_t;

	// exp is the boot rom word address on a pif low half
	// and the boot rom word on a pif high half
	// and cart_loaded for OP_FLAG
	typedef struct packed {
		op_t op;
		logic [7:0] idx;
		logic [26:0] addr;
		logic [15:0] data;
		mem_be_t be;
		mem_word_t exp;
		mem_addr_t saddr;
	} entry_t;

	localparam int N_TESTS = 25;
	localparam int WAIT_LIMIT = 40;

	// ========================================
	// stimulus table
	// ========================================

	localparam entry_t TESTS [N_TESTS] = '{
		// boot rom, index bit 6 set on the first word
		'{OP_HALF, 8'h40, 27'h0000010, 16'h1234, 4'h0, 32'h0000_0204, 14'h0000},
		'{OP_HALF, 8'h40, 27'h0000012, 16'h5678, 4'h0, 32'h3412_7856, 14'h0000},
		'{OP_HALF, 8'h00, 27'h00007f8, 16'hbeef, 4'h0, 32'h0000_01fe, 14'h0000},
		'{OP_HALF, 8'h00, 27'h00007fa, 16'hcafe, 4'h0, 32'hefbe_feca, 14'h0000},
		// game boy, second word wraps past the top of memory
		'{OP_HALF, 8'h02, 27'h0000020, 16'h1111, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF, 8'h02, 27'h0000022, 16'h2222, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF, 8'h02, 27'h0003004, 16'ha5a5, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF, 8'h02, 27'h0003006, 16'h5a5a, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_FLAG, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h1020},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h0004},
		// n64, last high half races a sys write
		'{OP_HALF, 8'h01, 27'h0000100, 16'h0123, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF, 8'h01, 27'h0000102, 16'h4567, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF, 8'h01, 27'h0000104, 16'h89ab, 4'h0, 32'h0000_0000, 14'h0000},
		'{OP_HALF_SYS, 8'h01, 27'h0000106, 16'hcdef, 4'hf, 32'h0000_0000, 14'h0800},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h2100},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h2104},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h0800},
		'{OP_FLAG, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0001, 14'h0000},
		// partial byte enables over a full word
		'{OP_SYS_WR, 8'h00, 27'h0000000, 16'h0000, 4'hf, 32'h0000_0000, 14'h0400},
		'{OP_SYS_WR, 8'h00, 27'h0000000, 16'h0000, 4'h5, 32'h0000_0000, 14'h0400},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h0400},
		'{OP_SYS_WR, 8'h00, 27'h0000000, 16'h0000, 4'hf, 32'h0000_0000, 14'h0404},
		'{OP_SYS_WR, 8'h00, 27'h0000000, 16'h0000, 4'h8, 32'h0000_0000, 14'h0404},
		'{OP_SYS_RD, 8'h00, 27'h0000000, 16'h0000, 4'h0, 32'h0000_0000, 14'h0404}
	};

	logic clk_1x;
	logic reset;
	logic ioctl_download;
	logic ioctl_wr;
	logic [7:0] ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wait;
	logic [`PIF_ADDR_BITS-1:0] pifrom_wraddress;
	mem_word_t pifrom_wrdata;
	logic pifrom_wren;
	logic cart_loaded;
	logic sys_req;
	logic sys_rnw;
	mem_addr_t sys_addr;
	mem_be_t sys_be;
	mem_word_t sys_wdata;
	logic sys_ack;
	mem_word_t sys_rdata;

	// reference copy of the shared memory
	mem_word_t model [`MEM_WORDS];
	logic [31:0] rng_state;
	int errors;
	int checks;
	logic dl_open;
	logic [7:0] dl_idx;
	// low half waiting for its partner
	logic [15:0] pend_lo;
	mem_addr_t pend_addr;
	logic [`PIF_ADDR_BITS-1:0] pend_pif_addr;

	rom_loader_top dut0 (.*);

	initial clk_1x = 1'b0;
	always #20 clk_1x = ~clk_1x;

	// ========================================
	// helpers
	// ========================================

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// host may not write while the loader holds it off
	task automatic wait_host_ready();
		int n;
		n = 0;
		while (ioctl_wait && n < WAIT_LIMIT) begin
			@(negedge clk_1x);
			n++;
		end
		if (ioctl_wait) begin
			$display("ioctl_wait stayed high for %0d cycles at %0t ns", WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	task automatic close_download();
		wait_host_ready();
		@(negedge clk_1x);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
		dl_open = 1'b0;
	endtask

	task automatic open_download(input logic [7:0] idx);
		if (!dl_open || dl_idx != idx) begin
			if (dl_open) begin
				close_download();
			end
			@(negedge clk_1x);
			ioctl_download = 1'b1;
			ioctl_index = idx;
			// target decode lags one cycle
			@(negedge clk_1x);
			dl_open = 1'b1;
			dl_idx = idx;
		end
	endtask

	task automatic host_half(input logic [7:0] idx, input logic [26:0] addr,
			input logic [15:0] dout, input mem_word_t exp);
		logic [26:0] sum;
		logic cart;
		cart = (idx[5:0] == `DL_IDX_N64) || (idx[5:0] == `DL_IDX_GB);
		sum = addr + ((idx[5:0] == `DL_IDX_N64) ? 27'(`CART_N64_BASE) : 27'(`CART_GB_BASE));
		wait_host_ready();
		@(negedge clk_1x);
		ioctl_wr = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = dout;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
		if (!cart) begin
			// boot rom strobe only after a high half
			check_equal(32'(pifrom_wren), {31'd0, addr[1]}, "pifrom_wren");
			check_equal(32'(ioctl_wait), 32'd0, "ioctl_wait during boot rom load");
			if (!addr[1]) begin
				pend_pif_addr = exp[`PIF_ADDR_BITS-1:0];
			end else begin
				check_equal(pifrom_wrdata, exp, "boot rom word");
				check_equal(32'(pifrom_wraddress), 32'(pend_pif_addr), "boot rom address");
				@(negedge clk_1x);
				check_equal(32'(pifrom_wren), 32'd0, "pifrom_wren longer than one cycle");
				// a cartridge style request would reach the memory by now
				check_equal(32'(dut0.mem_en), 32'd0, "memory access during boot rom load");
			end
		end else if (!addr[1]) begin
			pend_lo = dout;
			pend_addr = sum[`MEM_ADDR_BITS-1:0];
		end else begin
			check_equal(32'(ioctl_wait), 32'd1, "ioctl_wait after high half");
			// high half above low half
			model[pend_addr[`MEM_ADDR_BITS-1:2]] = {dout, pend_lo};
			wait_host_ready();
		end
	endtask

	// one four-phase transfer on the sys port
	task automatic sys_access(input logic rnw, input mem_addr_t addr, input mem_be_t be,
			input mem_word_t wdata, output mem_word_t rdata);
		int n;
		rdata = '0;
		@(negedge clk_1x);
		sys_req = 1'b1;
		sys_rnw = rnw;
		sys_addr = addr;
		sys_be = be;
		sys_wdata = wdata;
		n = 0;
		do begin
			@(negedge clk_1x);
			n++;
		end while (!sys_ack && n < WAIT_LIMIT);
		if (sys_ack) begin
			rdata = sys_rdata;
		end else begin
			$display("no sys_ack for address %h within %0d cycles", addr, WAIT_LIMIT);
			errors++;
		end
		sys_req = 1'b0;
		n = 0;
		while (sys_ack && n < WAIT_LIMIT) begin
			@(negedge clk_1x);
			n++;
		end
		if (sys_ack) begin
			$display("sys_ack never dropped after req fell at %0t ns", $time);
			errors++;
		end
	endtask

	task automatic sys_write(input mem_addr_t addr, input mem_be_t be);
		mem_word_t data;
		mem_word_t rd_unused;
		rng_state = xorshift32(rng_state);
		data = rng_state;
		sys_access(1'b0, addr, be, data, rd_unused);
		// only enabled lanes change
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				model[addr[`MEM_ADDR_BITS-1:2]][8*i +: 8] = data[8*i +: 8];
			end
		end
	endtask

	task automatic sys_read_check(input mem_addr_t addr);
		mem_word_t rd;
		sys_access(1'b1, addr, 4'h0, 32'h0, rd);
		check_equal(rd, model[addr[`MEM_ADDR_BITS-1:2]], $sformatf("sys read at %h", addr));
	endtask

	task automatic apply_entry(input entry_t e);
		case (e.op)
			OP_HALF: begin
				open_download(e.idx);
				host_half(e.idx, e.addr, e.data, e.exp);
			end
			OP_HALF_SYS: begin
				open_download(e.idx);
				fork
					host_half(e.idx, e.addr, e.data, e.exp);
					begin
						// one cycle behind so both requests meet at the arbiter
						@(negedge clk_1x);
						sys_write(e.saddr, e.be);
					end
				join
			end
			OP_SYS_WR: sys_write(e.saddr, e.be);
			OP_SYS_RD: sys_read_check(e.saddr);
			default: check_equal(32'(cart_loaded), e.exp, "cart_loaded");
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = 27'h0;
		ioctl_dout = 16'h0;
		sys_req = 1'b0;
		sys_rnw = 1'b1;
		sys_addr = '0;
		sys_be = '0;
		sys_wdata = '0;
		errors = 0;
		checks = 0;
		dl_open = 1'b0;
		dl_idx = 8'h00;
		rng_state = 32'h63c7_6a68;
		repeat (4) @(negedge clk_1x);
		reset = 1'b0;
		@(negedge clk_1x);
		check_equal(32'(ioctl_wait), 32'd0, "ioctl_wait after reset");
		check_equal(32'(pifrom_wren), 32'd0, "pifrom_wren after reset");
		check_equal(32'(sys_ack), 32'd0, "sys_ack after reset");
		check_equal(32'(cart_loaded), 32'd0, "cart_loaded after reset");
		for (int i = 0; i < N_TESTS; i++) begin
			apply_entry(TESTS[i]);
		end
		if (dl_open) begin
			close_download();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog, 40 cycles per table entry
	initial begin
		#(N_TESTS * WAIT_LIMIT * 40);
		$display("watchdog expired before the table finished at %0t ns", $time);
		$display(">>> FAIL");
		$finish;
	end

endmodule
